/* ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// station geometry
`define RS_SIZE     4
`define RS_SEL      2

// datapath widths
`define DATA_WIDTH  32
`define TAG_WIDTH   4
`define OP_WIDTH    3

// tag 0 means the operand value is present
`define TAG_FREE    {`TAG_WIDTH{1'b0}}

// alu opcodes
`define OP_ADD      3'd0
`define OP_SUB      3'd1
`define OP_AND      3'd2
`define OP_OR       3'd3
`define OP_XOR      3'd4
`define OP_SLT      3'd5
`define OP_SLL      3'd6

`endif

/* ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

    // operand or result value
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // producer tag, TAG_FREE when the value is known
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // alu operation code
    typedef logic [`OP_WIDTH-1:0] alu_op_t;

    // reservation station entry index
    typedef logic [`RS_SEL-1:0] rs_idx_t;

endpackage

/* ooo_if.sv */
`timescale 1ns/1ps

// decoder to reservation station
interface dispatch_if import ooo_pkg::*; ();
    logic    valid;
    logic    ready;
    alu_op_t op;
    tag_t    tag1;
    data_t   data1;
    tag_t    tag2;
    data_t   data2;
    tag_t    dest;

    modport source (
        output valid, op, tag1, data1, tag2, data2, dest,
        input  ready
    );

    modport target (
        input  valid, op, tag1, data1, tag2, data2, dest,
        output ready
    );
endinterface

// reservation station to alu stage
interface issue_if import ooo_pkg::*; ();
    logic    valid;
    logic    ready;
    data_t   src1;
    data_t   src2;
    alu_op_t op;
    tag_t    dest;

    modport source (
        output valid, src1, src2, op, dest,
        input  ready
    );

    modport sink (
        input  valid, src1, src2, op, dest,
        output ready
    );
endinterface

/* rs_entry.sv */
`timescale 1ns/1ps

`include "ooo_consts.svh"

module rs_entry
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    alloc,
    input  logic    busy,
    input  alu_op_t op,
    input  tag_t    tag1,
    input  data_t   data1,
    input  tag_t    tag2,
    input  data_t   data2,
    input  tag_t    dest,
    input  logic    cdb_valid,
    input  tag_t    cdb_tag,
    input  data_t   cdb_data,
    output data_t   src1,
    output data_t   src2,
    output alu_op_t entry_op,
    output tag_t    entry_dest,
    output logic    ready
);
    tag_t    tag1_q;
    tag_t    tag2_q;
    data_t   data1_q;
    data_t   data2_q;
    alu_op_t op_q;
    tag_t    dest_q;
    logic    hit1;
    logic    hit2;
    logic    in_hit1;
    logic    in_hit2;

    // held operands still waiting on a producer
    assign hit1 = cdb_valid && (tag1_q != `TAG_FREE) && (tag1_q == cdb_tag);
    assign hit2 = cdb_valid && (tag2_q != `TAG_FREE) && (tag2_q == cdb_tag);

    // operands arriving with a dispatch in the broadcast cycle
    assign in_hit1 = cdb_valid && (tag1 != `TAG_FREE) && (tag1 == cdb_tag);
    assign in_hit2 = cdb_valid && (tag2 != `TAG_FREE) && (tag2 == cdb_tag);

    // bypass so issue can happen in the broadcast cycle
    assign src1       = hit1 ? cdb_data : data1_q;
    assign src2       = hit2 ? cdb_data : data2_q;
    assign entry_op   = op_q;
    assign entry_dest = dest_q;
    assign ready      = busy && (hit1 || (tag1_q == `TAG_FREE))
                             && (hit2 || (tag2_q == `TAG_FREE));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag1_q <= `TAG_FREE;
            tag2_q <= `TAG_FREE;
        end else if (alloc) begin
            tag1_q <= in_hit1 ? `TAG_FREE : tag1;
            tag2_q <= in_hit2 ? `TAG_FREE : tag2;
        end else begin
            if (hit1)
                tag1_q <= `TAG_FREE;
            if (hit2)
                tag2_q <= `TAG_FREE;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            data1_q <= in_hit1 ? cdb_data : data1;
            data2_q <= in_hit2 ? cdb_data : data2;
            op_q    <= op;
            dest_q  <= dest;
        end else begin
            if (hit1)
                data1_q <= cdb_data;
            if (hit2)
                data2_q <= cdb_data;
        end
    end

endmodule

/* alu_rs.sv */
`timescale 1ns/1ps

`include "ooo_consts.svh"

module alu_rs
    import ooo_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    dispatch_if.target     disp,
    issue_if.source        iss,
    input  logic           cdb_valid,
    input  tag_t           cdb_tag,
    input  data_t          cdb_data
);
    logic [`RS_SIZE-1:0] busy;
    logic [`RS_SIZE-1:0] ent_ready;
    data_t               ent_src1 [`RS_SIZE];
    data_t               ent_src2 [`RS_SIZE];
    alu_op_t             ent_op   [`RS_SIZE];
    tag_t                ent_dest [`RS_SIZE];

    logic    any_free;
    rs_idx_t free_idx;
    logic    any_ready;
    rs_idx_t ready_idx;
    logic    alloc_go;
    logic    issue_go;

    logic    iss_valid_q;
    data_t   iss_src1_q;
    data_t   iss_src2_q;
    alu_op_t iss_op_q;
    tag_t    iss_dest_q;

    // lowest free entry
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                any_free = 1'b1;
                free_idx = rs_idx_t'(i);
            end
        end
    end

    // lowest ready entry
    always_comb begin
        any_ready = 1'b0;
        ready_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (ent_ready[i]) begin
                any_ready = 1'b1;
                ready_idx = rs_idx_t'(i);
            end
        end
    end

    assign disp.ready = any_free;
    assign alloc_go   = disp.valid && any_free;
    // issue register empty or draining this cycle
    assign issue_go   = any_ready && (!iss_valid_q || iss.ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (alloc_go)
                busy[free_idx] <= 1'b1;
            if (issue_go)
                busy[ready_idx] <= 1'b0;
        end
    end

    for (genvar g = 0; g < `RS_SIZE; g++) begin : g_entry
        rs_entry u_rs_entry (
            .clk        (clk),
            .rst        (rst),
            .alloc      (alloc_go && (free_idx == rs_idx_t'(g))),
            .busy       (busy[g]),
            .op         (disp.op),
            .tag1       (disp.tag1),
            .data1      (disp.data1),
            .tag2       (disp.tag2),
            .data2      (disp.data2),
            .dest       (disp.dest),
            .cdb_valid  (cdb_valid),
            .cdb_tag    (cdb_tag),
            .cdb_data   (cdb_data),
            .src1       (ent_src1[g]),
            .src2       (ent_src2[g]),
            .entry_op   (ent_op[g]),
            .entry_dest (ent_dest[g]),
            .ready      (ent_ready[g])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            iss_valid_q <= 1'b0;
        else if (issue_go)
            iss_valid_q <= 1'b1;
        else if (iss.ready)
            iss_valid_q <= 1'b0;
    end

    // payload held while the alu stage stalls
    always_ff @(posedge clk) begin
        if (issue_go) begin
            iss_src1_q <= ent_src1[ready_idx];
            iss_src2_q <= ent_src2[ready_idx];
            iss_op_q   <= ent_op[ready_idx];
            iss_dest_q <= ent_dest[ready_idx];
        end
    end

    assign iss.valid = iss_valid_q;
    assign iss.src1  = iss_src1_q;
    assign iss.src2  = iss_src2_q;
    assign iss.op    = iss_op_q;
    assign iss.dest  = iss_dest_q;

endmodule

/* alu_exec.sv */
`timescale 1ns/1ps

`include "ooo_consts.svh"

module alu_exec
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    issue_if.sink   iss,
    input  logic    load_valid,
    input  tag_t    load_tag,
    input  data_t   load_data,
    output logic    cdb_valid,
    output tag_t    cdb_tag,
    output data_t   cdb_data
);
    data_t alu_out;
    logic  res_valid;
    tag_t  res_tag;
    data_t res_data;
    logic  accept;
    logic  alu_sent;

    always_comb begin
        case (iss.op)
            `OP_ADD: alu_out = iss.src1 + iss.src2;
            `OP_SUB: alu_out = iss.src1 - iss.src2;
            `OP_AND: alu_out = iss.src1 & iss.src2;
            `OP_OR:  alu_out = iss.src1 | iss.src2;
            `OP_XOR: alu_out = iss.src1 ^ iss.src2;
            `OP_SLT: alu_out = data_t'($signed(iss.src1) < $signed(iss.src2));
            `OP_SLL: alu_out = iss.src1 << iss.src2[4:0];
            default: alu_out = '0;
        endcase
    end

    // load results win the bus
    assign alu_sent  = res_valid && !load_valid;
    assign iss.ready = !res_valid || alu_sent;
    assign accept    = iss.valid && iss.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            res_valid <= 1'b0;
        else if (accept)
            res_valid <= 1'b1;
        else if (alu_sent)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_data <= alu_out;
            res_tag  <= iss.dest;
        end
    end

    assign cdb_valid = load_valid || res_valid;
    assign cdb_tag   = load_valid ? load_tag : res_tag;
    assign cdb_data  = load_valid ? load_data : res_data;

endmodule

/* ooo_alu_top.sv */
`timescale 1ns/1ps

module ooo_alu_top
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    dispatch_valid,
    output logic    dispatch_ready,
    input  alu_op_t dispatch_op,
    input  tag_t    dispatch_tag1,
    input  data_t   dispatch_data1,
    input  tag_t    dispatch_tag2,
    input  data_t   dispatch_data2,
    input  tag_t    dispatch_dest,
    input  logic    load_valid,
    input  tag_t    load_tag,
    input  data_t   load_data,
    output logic    cdb_valid,
    output tag_t    cdb_tag,
    output data_t   cdb_data
);
    dispatch_if disp_bus ();
    issue_if    iss_bus ();

    // decoder side onto the dispatch bundle
    assign disp_bus.valid = dispatch_valid;
    assign disp_bus.op    = dispatch_op;
    assign disp_bus.tag1  = dispatch_tag1;
    assign disp_bus.data1 = dispatch_data1;
    assign disp_bus.tag2  = dispatch_tag2;
    assign disp_bus.data2 = dispatch_data2;
    assign disp_bus.dest  = dispatch_dest;
    assign dispatch_ready = disp_bus.ready;

    alu_rs u_alu_rs (
        .clk       (clk),
        .rst       (rst),
        .disp      (disp_bus),
        .iss       (iss_bus),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data)
    );

    // also owns the cdb mux
    alu_exec u_alu_exec (
        .clk        (clk),
        .rst        (rst),
        .iss        (iss_bus),
        .load_valid (load_valid),
        .load_tag   (load_tag),
        .load_data  (load_data),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data)
    );

endmodule

/* ooo_alu_asserts.sv */
`timescale 1ns/1ps

`include "ooo_consts.svh"

module ooo_alu_asserts
    import ooo_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    dispatch_valid,
    input logic    dispatch_ready,
    input alu_op_t dispatch_op,
    input tag_t    dispatch_tag1,
    input data_t   dispatch_data1,
    input tag_t    dispatch_tag2,
    input data_t   dispatch_data2,
    input tag_t    dispatch_dest,
    input logic    load_valid,
    input tag_t    load_tag,
    input data_t   load_data,
    input logic    cdb_valid,
    input tag_t    cdb_tag,
    input data_t   cdb_data
);
    // offered instruction held until taken
    dispatch_stable: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && !dispatch_ready |=> dispatch_valid
            && $stable({dispatch_op, dispatch_tag1, dispatch_data1,
                        dispatch_tag2, dispatch_data2, dispatch_dest}))
        else $error("dispatch payload changed while stalled");

    cdb_tag_used: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_tag != `TAG_FREE)
        else $error("cdb broadcast with free tag");

    // load wins the bus
    load_on_cdb: assert property (@(posedge clk) disable iff (rst)
        load_valid |-> cdb_valid && cdb_tag == load_tag && cdb_data == load_data)
        else $error("load result not on cdb");

endmodule

bind ooo_alu_top ooo_alu_asserts u_ooo_alu_asserts (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_op    (dispatch_op),
    .dispatch_tag1  (dispatch_tag1),
    .dispatch_data1 (dispatch_data1),
    .dispatch_tag2  (dispatch_tag2),
    .dispatch_data2 (dispatch_data2),
    .dispatch_dest  (dispatch_dest),
    .load_valid     (load_valid),
    .load_tag       (load_tag),
    .load_data      (load_data),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .cdb_data       (cdb_data)
);

/* tb_ooo_alu.sv */
`timescale 1ns/1ps

`include "ooo_consts.svh"

module tb_ooo_alu
    import ooo_pkg::*;
();
    localparam int TIMEOUT = 200;

    logic    clk;
    logic    rst;
    logic    dispatch_valid;
    logic    dispatch_ready;
    alu_op_t dispatch_op;
    tag_t    dispatch_tag1;
    data_t   dispatch_data1;
    tag_t    dispatch_tag2;
    data_t   dispatch_data2;
    tag_t    dispatch_dest;
    logic    load_valid;
    tag_t    load_tag;
    data_t   load_data;
    logic    cdb_valid;
    tag_t    cdb_tag;
    data_t   cdb_data;

    // scoreboard indexed by dest tag
    logic [(1<<`TAG_WIDTH)-1:0] pending;
    data_t expect_data [1<<`TAG_WIDTH];
    logic  full_seen;

    ooo_alu_top u_ooo_alu_top (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_op    (dispatch_op),
        .dispatch_tag1  (dispatch_tag1),
        .dispatch_data1 (dispatch_data1),
        .dispatch_tag2  (dispatch_tag2),
        .dispatch_data2 (dispatch_data2),
        .dispatch_dest  (dispatch_dest),
        .load_valid     (load_valid),
        .load_tag       (load_tag),
        .load_data      (load_data),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data)
    );

    always #20 clk = ~clk;

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        stop_fail($sformatf("Error at %0d ns: %s", $time, msg));
    endtask

    // load pulses last one cycle
    task automatic cycle_end();
        @(posedge clk);
        #2;
        load_valid = 1'b0;
    endtask

    task automatic dispatch_one(input alu_op_t op, input tag_t t1, input data_t d1,
                                input tag_t t2, input data_t d2, input tag_t dest,
                                input data_t result);
        int   cnt;
        logic accepted;
        cnt = 0;
        // dest tag reuse only after the earlier result is out
        while (pending[dest]) begin
            cycle_end();
            cnt++;
            if (cnt > TIMEOUT)
                stop_fail($sformatf("timeout waiting for tag %0h to retire", dest));
        end
        pending[dest]     = 1'b1;
        expect_data[dest] = result;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag1  = t1;
        dispatch_data1 = d1;
        dispatch_tag2  = t2;
        dispatch_data2 = d2;
        dispatch_dest  = dest;
        accepted = 1'b0;
        cnt = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = dispatch_ready;
            cycle_end();
            cnt++;
            if (cnt > TIMEOUT)
                stop_fail("timeout waiting for dispatch_ready");
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic load_one(input int wait_cycles, input tag_t tag, input data_t data);
        repeat (wait_cycles) cycle_end();
        // keep back-to-back loads in separate cycles
        if (load_valid)
            cycle_end();
        load_valid = 1'b1;
        load_tag   = tag;
        load_data  = data;
    endtask

    // result checker, mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!dispatch_ready)
                full_seen = 1'b1;
            if (cdb_valid && !load_valid) begin
                assert (pending[cdb_tag])
                else value_error($sformatf("unexpected or repeated cdb tag %0h", cdb_tag));
                assert (cdb_data == expect_data[cdb_tag])
                else value_error($sformatf("tag %0h result %08h, expected %08h",
                                           cdb_tag, cdb_data, expect_data[cdb_tag]));
                pending[cdb_tag] = 1'b0;
            end
        end
    end

    initial begin
        int      fd;
        int      n;
        int      cnt;
        int      wait_cycles;
        string   kind;
        string   rest;
        alu_op_t op;
        tag_t    t1;
        tag_t    t2;
        tag_t    dest;
        data_t   d1;
        data_t   d2;
        data_t   result;

        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;
        dispatch_tag1  = '0;
        dispatch_data1 = '0;
        dispatch_tag2  = '0;
        dispatch_data2 = '0;
        dispatch_dest  = '0;
        load_valid     = 1'b0;
        load_tag       = '0;
        load_data      = '0;
        pending        = '0;
        full_seen      = 1'b0;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        assert (!cdb_valid && dispatch_ready)
        else value_error("wrong cdb_valid or dispatch_ready after reset");
        cycle_end();

        fd = $fopen("ooo_alu_testdata.txt", "r");
        if (fd == 0)
            stop_fail("could not open ooo_alu_testdata.txt");

        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1)
                break;
            if (kind == "D") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h", op, t1, d1, t2, d2, dest, result);
                if (n != 7)
                    stop_fail("malformed D record in test data");
                dispatch_one(op, t1, d1, t2, d2, dest, result);
            end else if (kind == "L") begin
                n = $fscanf(fd, "%d %h %h", wait_cycles, t1, d1);
                if (n != 3)
                    stop_fail("malformed L record in test data");
                load_one(wait_cycles, t1, d1);
            end else begin
                // comment line
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        cycle_end();

        cnt = 0;
        while (|pending) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT)
                stop_fail("timeout waiting for outstanding results");
        end

        assert (full_seen)
        else value_error("dispatch_ready never went low with the station full");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* ooo_alu_testdata.txt */
# D op tag1 data1 tag2 data2 dest expected (all hex)
# L wait_cycles(dec) tag data(hex)
# known operands, every opcode
D 0 0 00000005 0 00000007 1 0000000c
D 1 0 00000003 0 00000005 2 fffffffe
D 2 0 f0f0f0f0 0 ff00ff00 3 f000f000
D 3 0 f0f0f0f0 0 0f0f0000 4 fffff0f0
D 4 0 aaaaaaaa 0 ffffffff 5 55555555
D 5 0 fffffffe 0 00000001 6 00000001
D 5 0 00000001 0 fffffffe 7 00000000
D 6 0 00000001 0 00000024 8 00000010
# dependency chain
D 0 0 00000010 0 00000020 9 00000030
D 1 9 00000000 0 00000008 a 00000028
D 6 a 00000000 0 00000002 b 000000a0
# load wakeup, second consumer dispatched with the broadcast
D 0 e 00000000 0 00000001 c 00000101
L 1 e 00000100
D 2 e 00000000 0 0000ffff d 00000100
# station full behind load tag f
D 0 f 00000000 0 00000001 1 00001001
D 1 f 00000000 0 00000010 2 00000ff0
D 4 0 ffffffff f 00000000 3 ffffefff
D 0 f 00000000 f 00000000 4 00002000
L 3 f 00001000
# loads on consecutive cycles against alu results
D 0 0 00000001 0 00000002 5 00000003
D 0 0 00000003 0 00000004 6 00000007
D 0 0 00000005 0 00000006 7 0000000b
D 0 0 00000007 0 00000008 8 0000000f
L 0 e 00000011
L 0 f 00000022
L 0 e 00000033
D 1 0 00000009 0 00000001 9 00000008
L 0 f 00000044
D 0 0 00000001 0 00000001 a 00000002
L 0 e 00000055
L 0 f 00000066

/* sim.f */
+incdir+.
ooo_pkg.sv
ooo_if.sv
rs_entry.sv
alu_rs.sv
alu_exec.sv
ooo_alu_top.sv
ooo_alu_asserts.sv
tb_ooo_alu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_ooo_alu -o Vtb_ooo_alu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ooo_alu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
